/* Makefile */
VERILATOR ?= verilator
TOP ?= meterTb
VFLAGS ?= --binary --timing -j 0
OBJ_DIR ?= obj_dir
PASS_TEXT ?= Testbench passed

SRCS := $(shell grep -v '^+' verilog.f)
HDRS := include/meter_settings.svh
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) verilog.f
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f verilog.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* include/meter_settings.svh */
`ifndef METER_SETTINGS_SVH
`define METER_SETTINGS_SVH

// Host data word, bits 18..35 of the board's EBUS
`define MTR_WORD_W 18

// Meter width, one bit short of the host word
`define MTR_COUNT_W 17

// Interval period and interval counter
`define MTR_PERIOD_W 12

// MBOX_CLK cycles per microsecond tick
`define MTR_USEC_DIV 4

`endif

/* rtl/meterControl.sv */
`timescale 1ns/10ps
`default_nettype none

`include "meter_settings.svh"

module meterControl (
  input  logic MBOX_CLK,
  input  logic RESET,
  input  logic req,
  input  meter_pkg::meterCmd cmd,
  input  logic [`MTR_WORD_W-1:0] readWord,
  output logic ack,
  output logic [`MTR_WORD_W-1:0] rdata,
  output meter_pkg::meterStrobes strobes,
  output meter_pkg::meterWord cmdWord,
  output meter_pkg::meterSel sel
);
  import meter_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    EXEC,
    ACK,
    RELEASE
  } ctlState;

  ctlState state;
  ctlState nextState;
  logic start;
  meterStrobes decode;

  assign start = (state == IDLE) && req;

  always_comb begin
    nextState = state;
    case (state)
      IDLE:    if (req) nextState = EXEC;
      EXEC:    nextState = ACK;
      // Host dropped req early, so never raise ack
      ACK:     nextState = req ? RELEASE : IDLE;
      RELEASE: if (!req) nextState = IDLE;
      default: nextState = IDLE;
    endcase
  end

  always_ff @(posedge MBOX_CLK) begin
    if (RESET)
      state <= IDLE;
    else
      state <= nextState;
  end

  always_comb begin
    decode = '0;
    case (cmd.op)
      CONO_MTR: decode.loadMtr = 1'b1;
      CONO_TIM: decode.loadTim = 1'b1;
      LOAD_PA:  decode.loadMask = 1'b1;
      READ:     decode.readEn = 1'b1;
      default:  decode = '0;
    endcase
  end

  // Strobes are high for the EXEC cycle only
  always_ff @(posedge MBOX_CLK) begin
    if (RESET)
      strobes <= '0;
    else
      strobes <= start ? decode : '0;
  end

  always_ff @(posedge MBOX_CLK) begin
    if (start) begin
      cmdWord <= cmd.data;
      sel <= cmd.sel;
    end
  end

  // Values registered before the strobe edge
  always_ff @(posedge MBOX_CLK) begin
    if (state == EXEC)
      rdata <= readWord;
  end

  assign ack = (state == RELEASE);

endmodule

`default_nettype wire

/* rtl/meterCounters.sv */
`timescale 1ns/10ps
`default_nettype none

`include "meter_settings.svh"

module meterCounters (
  input  logic MBOX_CLK,
  input  logic RESET,
  input  meter_pkg::meterStrobes strobes,
  input  meter_pkg::meterWord cmdWord,
  input  meter_pkg::meterEvents events,
  input  logic usecTick,
  output logic [`MTR_COUNT_W-1:0] timeCount,
  output logic [`MTR_COUNT_W-1:0] eboxCount,
  output logic [`MTR_COUNT_W-1:0] cacheCount,
  output logic [`MTR_COUNT_W-1:0] perfCount,
  output logic acctOn,
  output logic timeOn,
  output meter_pkg::meterEvents perfMask
);

  // Meter index order is time, EBOX, cache, perf
  localparam int NumMeters = 4;

  logic [NumMeters-1:0] countEn;
  logic [NumMeters-1:0] clearSel;
  logic [NumMeters-1:0][`MTR_COUNT_W-1:0] meters;

  always_ff @(posedge MBOX_CLK) begin
    if (RESET) begin
      acctOn <= 1'b0;
      timeOn <= 1'b0;
      perfMask <= '0;
    end else begin
      if (strobes.loadMtr) begin
        acctOn <= cmdWord.mtr.acctOn;
        timeOn <= (timeOn & ~cmdWord.mtr.timeOnClr) | cmdWord.mtr.timeOnSet;
      end
      if (strobes.loadMask)
        perfMask <= cmdWord.raw[$bits(perfMask)-1:0];
    end
  end

  assign clearSel = {NumMeters{strobes.loadMtr}} &
                    {cmdWord.mtr.clearPerf, cmdWord.mtr.clearCache,
                     cmdWord.mtr.clearEbox, cmdWord.mtr.clearTime};

  // Events pass through one register stage
  always_ff @(posedge MBOX_CLK) begin
    if (RESET) begin
      countEn <= '0;
    end else begin
      countEn[0] <= timeOn & usecTick;
      countEn[1] <= acctOn & events.eboxRun & ~events.eboxWait;
      countEn[2] <= acctOn & events.mbXfer;
      countEn[3] <= acctOn & (|(events & perfMask));
    end
  end

  always_ff @(posedge MBOX_CLK) begin
    if (RESET) begin
      meters <= '0;
    end else begin
      for (int i = 0; i < NumMeters; i++) begin
        if (clearSel[i])
          meters[i] <= '0;
        else if (countEn[i])
          meters[i] <= meters[i] + 1'b1;
      end
    end
  end

  assign timeCount = meters[0];
  assign eboxCount = meters[1];
  assign cacheCount = meters[2];
  assign perfCount = meters[3];

endmodule

`default_nettype wire

/* rtl/meterReadback.sv */
`timescale 1ns/10ps
`default_nettype none

`include "meter_settings.svh"

module meterReadback (
  input  meter_pkg::meterSel sel,
  input  logic [`MTR_COUNT_W-1:0] timeCount,
  input  logic [`MTR_COUNT_W-1:0] perfCount,
  input  logic [`MTR_COUNT_W-1:0] eboxCount,
  input  logic [`MTR_COUNT_W-1:0] cacheCount,
  input  logic [`MTR_PERIOD_W-1:0] intervalValue,
  input  logic [`MTR_PERIOD_W-1:0] period,
  input  meter_pkg::meterStatus status,
  output logic [`MTR_WORD_W-1:0] readWord
);
  import meter_pkg::*;

  always_comb begin
    readWord = '0;
    case (sel)
      TIME:     readWord[`MTR_COUNT_W-1:0] = timeCount;
      PERF:     readWord[`MTR_COUNT_W-1:0] = perfCount;
      EBOX:     readWord[`MTR_COUNT_W-1:0] = eboxCount;
      CACHE:    readWord[`MTR_COUNT_W-1:0] = cacheCount;
      INTERVAL: readWord[`MTR_PERIOD_W-1:0] = intervalValue;
      PERIOD:   readWord[`MTR_PERIOD_W-1:0] = period;
      STATUS: begin
        // Timer flags sit on EBUS bits 21..23, time on at bit 25
        readWord[14] = status.intervalOn;
        readWord[13] = status.intervalDone;
        readWord[12] = status.intervalOverflow;
        readWord[11] = status.acctOn;
        readWord[10] = status.timeOn;
        readWord[$bits(status.perfMask)-1:0] = status.perfMask;
      end
      default:  readWord = '0;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/meterTimebase.sv */
`timescale 1ns/10ps
`default_nettype none

`include "meter_settings.svh"

module meterTimebase (
  input  logic MBOX_CLK,
  input  logic RESET,
  input  meter_pkg::meterStrobes strobes,
  input  meter_pkg::meterWord cmdWord,
  output logic usecTick,
  output logic [`MTR_PERIOD_W-1:0] intervalValue,
  output logic [`MTR_PERIOD_W-1:0] period,
  output logic intervalOn,
  output logic done,
  output logic overflow,
  output logic interrupt
);

  localparam int DivW = (`MTR_USEC_DIV > 1) ? $clog2(`MTR_USEC_DIV) : 1;

  logic [DivW-1:0] divCount;
  logic match;
  logic wrap;

  // Microsecond divider
  always_ff @(posedge MBOX_CLK) begin
    if (RESET) begin
      divCount <= '0;
      usecTick <= 1'b0;
    end else if (divCount == DivW'(`MTR_USEC_DIV - 1)) begin
      divCount <= '0;
      usecTick <= 1'b1;
    end else begin
      divCount <= divCount + 1'b1;
      usecTick <= 1'b0;
    end
  end

  // A zero period never matches
  assign match = intervalOn && (period != '0) && (intervalValue == period);
  assign wrap = intervalOn && usecTick && (&intervalValue) && !match;

  always_ff @(posedge MBOX_CLK) begin
    if (RESET) begin
      period <= '0;
      intervalOn <= 1'b0;
      intervalValue <= '0;
      done <= 1'b0;
      overflow <= 1'b0;
    end else begin
      if (strobes.loadTim) begin
        period <= cmdWord.tim.period;
        intervalOn <= cmdWord.tim.intervalOn;
      end

      if (strobes.loadTim && cmdWord.tim.clearInterval)
        intervalValue <= '0;
      else if (match)
        intervalValue <= '0;
      else if (intervalOn && usecTick)
        intervalValue <= intervalValue + 1'b1;

      if (strobes.loadTim && cmdWord.tim.clearDone) begin
        done <= 1'b0;
        overflow <= 1'b0;
      end else begin
        if (match)
          done <= 1'b1;
        if (wrap)
          overflow <= 1'b1;
      end
    end
  end

  assign interrupt = done && intervalOn;

endmodule

`default_nettype wire

/* rtl/meterTop.sv */
`timescale 1ns/10ps
`default_nettype none

`include "meter_settings.svh"

module meterTop (
  input  logic MBOX_CLK,
  input  logic RESET,
  input  logic req,
  input  meter_pkg::meterCmd cmd,
  input  meter_pkg::meterEvents events,
  output logic ack,
  output logic [`MTR_WORD_W-1:0] rdata,
  output logic interrupt
);
  import meter_pkg::*;

  meterStrobes strobes;
  meterWord cmdWord;
  meterSel sel;
  meterStatus status;
  meterEvents perfMask;
  logic [`MTR_WORD_W-1:0] readWord;
  logic usecTick;
  logic [`MTR_PERIOD_W-1:0] intervalValue;
  logic [`MTR_PERIOD_W-1:0] period;
  logic intervalOn;
  logic done;
  logic overflow;
  logic [`MTR_COUNT_W-1:0] timeCount;
  logic [`MTR_COUNT_W-1:0] eboxCount;
  logic [`MTR_COUNT_W-1:0] cacheCount;
  logic [`MTR_COUNT_W-1:0] perfCount;
  logic acctOn;
  logic timeOn;

  meterControl control (
    .MBOX_CLK (MBOX_CLK),
    .RESET    (RESET),
    .req      (req),
    .cmd      (cmd),
    .readWord (readWord),
    .ack      (ack),
    .rdata    (rdata),
    .strobes  (strobes),
    .cmdWord  (cmdWord),
    .sel      (sel)
  );

  meterTimebase timebase (
    .MBOX_CLK      (MBOX_CLK),
    .RESET         (RESET),
    .strobes       (strobes),
    .cmdWord       (cmdWord),
    .usecTick      (usecTick),
    .intervalValue (intervalValue),
    .period        (period),
    .intervalOn    (intervalOn),
    .done          (done),
    .overflow      (overflow),
    .interrupt     (interrupt)
  );

  meterCounters counters (
    .MBOX_CLK   (MBOX_CLK),
    .RESET      (RESET),
    .strobes    (strobes),
    .cmdWord    (cmdWord),
    .events     (events),
    .usecTick   (usecTick),
    .timeCount  (timeCount),
    .eboxCount  (eboxCount),
    .cacheCount (cacheCount),
    .perfCount  (perfCount),
    .acctOn     (acctOn),
    .timeOn     (timeOn),
    .perfMask   (perfMask)
  );

  always_comb begin
    status.acctOn = acctOn;
    status.timeOn = timeOn;
    status.intervalOn = intervalOn;
    status.intervalDone = done;
    status.intervalOverflow = overflow;
    status.perfMask = perfMask;
  end

  meterReadback readback (
    .sel           (sel),
    .timeCount     (timeCount),
    .perfCount     (perfCount),
    .eboxCount     (eboxCount),
    .cacheCount    (cacheCount),
    .intervalValue (intervalValue),
    .period        (period),
    .status        (status),
    .readWord      (readWord)
  );

endmodule

`default_nettype wire

/* rtl/meter_pkg.sv */
`default_nettype none

`include "meter_settings.svh"

package meter_pkg;

  typedef enum logic [1:0] {
    CONO_MTR,
    CONO_TIM,
    LOAD_PA,
    READ
  } meterOp;

  typedef enum logic [2:0] {
    TIME,
    PERF,
    EBOX,
    CACHE,
    INTERVAL,
    PERIOD,
    STATUS
  } meterSel;

  // CONO MTR decoding of the data word
  typedef struct packed {
    logic clearTime;
    logic timeOnSet;
    logic timeOnClr;
    logic acctOn;
    logic clearEbox;
    logic clearCache;
    logic clearPerf;
    logic [`MTR_WORD_W-8:0] spare;
  } meterMtrView;

  // CONO TIM decoding, period in the low bits
  typedef struct packed {
    logic clearInterval;
    logic clearDone;
    logic intervalOn;
    logic [`MTR_WORD_W-`MTR_PERIOD_W-4:0] spare;
    logic [`MTR_PERIOD_W-1:0] period;
  } meterTimView;

  typedef union packed {
    logic [`MTR_WORD_W-1:0] raw;
    meterMtrView mtr;
    meterTimView tim;
  } meterWord;

  typedef struct packed {
    meterOp op;
    meterSel sel;
    meterWord data;
  } meterCmd;

  // Also the layout of the perf mask
  typedef struct packed {
    logic eboxRun;
    logic eboxWait;
    logic mbXfer;
    logic cacheFill;
    logic writeback;
    logic userMode;
  } meterEvents;

  typedef struct packed {
    logic acctOn;
    logic timeOn;
    logic intervalOn;
    logic intervalDone;
    logic intervalOverflow;
    meterEvents perfMask;
  } meterStatus;

  typedef struct packed {
    logic loadMtr;
    logic loadTim;
    logic loadMask;
    logic readEn;
  } meterStrobes;

endpackage

`default_nettype wire

/* testbench/meter_checker.sv */
`timescale 1ns/10ps
`default_nettype none

`include "meter_settings.svh"

module meterChecker (
  input  logic MBOX_CLK,
  input  logic RESET,
  input  logic req,
  input  meter_pkg::meterCmd cmd,
  input  meter_pkg::meterEvents events,
  input  logic ack,
  input  logic [`MTR_WORD_W-1:0] rdata,
  input  logic interrupt,
  output int errorCount
);
  import meter_pkg::*;

  typedef enum logic [1:0] {
    HS_IDLE,
    HS_EXEC,
    HS_ACK,
    HS_RELEASE
  } hsState;

  hsState state;
  meterCmd held;
  meterEvents mask;
  logic acct;
  logic timeOn;
  logic tIntOn;
  logic tDone;
  logic tOvf;
  logic tick;
  logic pending;
  logic [`MTR_PERIOD_W-1:0] tPeriod;
  logic [`MTR_PERIOD_W-1:0] tValue;
  logic [2:0] en;
  logic [2:0] newEn;
  logic [`MTR_COUNT_W-1:0] ebox;
  logic [`MTR_COUNT_W-1:0] cache;
  logic [`MTR_COUNT_W-1:0] perf;
  logic [`MTR_WORD_W-1:0] expWord;
  int divPhase;
  int timeCycles;
  int expTime;
  int got;

  always @(posedge MBOX_CLK) begin
    if (RESET) begin
      state = HS_IDLE;
      held = '0;
      mask = '0;
      acct = 1'b0;
      timeOn = 1'b0;
      tIntOn = 1'b0;
      tDone = 1'b0;
      tOvf = 1'b0;
      tick = 1'b0;
      divPhase = 0;
      pending = 1'b0;
      tPeriod = '0;
      tValue = '0;
      en = '0;
      ebox = '0;
      cache = '0;
      perf = '0;
      timeCycles = 0;
      errorCount = 0;
    end else begin
      if (ack !== (state == HS_RELEASE)) begin
        errorCount++;
        $display("ERR ack got %h exp %h", ack, state == HS_RELEASE);
      end
      if (interrupt !== (tDone & tIntOn)) begin
        errorCount++;
        $display("ERR interrupt got %h exp %h", interrupt, tDone & tIntOn);
      end
      // rdata checked at the first cycle of ack
      if (pending && state == HS_RELEASE) begin
        pending = 1'b0;
        if (held.sel == TIME) begin
          got = int'(rdata);
          if (got > expTime + 1 || got + 1 < expTime) begin
            errorCount++;
            $display("ERR rdata(TIME) got %h exp %h", rdata, expTime);
          end
        end else if (rdata !== expWord) begin
          errorCount++;
          $display("ERR rdata(%s) got %h exp %h", held.sel.name(), rdata, expWord);
        end
      end

      if (state == HS_EXEC && held.op == READ) begin
        expWord = '0;
        expTime = timeCycles / `MTR_USEC_DIV;
        case (held.sel)
          PERF:     expWord[`MTR_COUNT_W-1:0] = perf;
          EBOX:     expWord[`MTR_COUNT_W-1:0] = ebox;
          CACHE:    expWord[`MTR_COUNT_W-1:0] = cache;
          INTERVAL: expWord[`MTR_PERIOD_W-1:0] = tValue;
          PERIOD:   expWord[`MTR_PERIOD_W-1:0] = tPeriod;
          STATUS: begin
            expWord[14] = tIntOn;
            expWord[13] = tDone;
            expWord[12] = tOvf;
            expWord[11] = acct;
            expWord[10] = timeOn;
            expWord[5:0] = mask;
          end
          default: expWord = '0;
        endcase
        pending = 1'b1;
      end

      // Meters count one cycle after the event is seen
      newEn[2] = acct & events.eboxRun & ~events.eboxWait;
      newEn[1] = acct & events.mbXfer;
      newEn[0] = acct & (|(events & mask));
      if (timeOn)
        timeCycles++;
      if (en[2])
        ebox = ebox + 1'b1;
      if (en[1])
        cache = cache + 1'b1;
      if (en[0])
        perf = perf + 1'b1;
      en = newEn;

      // Interval counter steps on the microsecond tick
      if (tIntOn && tPeriod != '0 && tValue == tPeriod) begin
        tValue = '0;
        tDone = 1'b1;
      end else if (tIntOn && tick) begin
        if (&tValue)
          tOvf = 1'b1;
        tValue = tValue + 1'b1;
      end
      tick = (divPhase == `MTR_USEC_DIV - 1);
      divPhase = tick ? 0 : divPhase + 1;

      if (state == HS_EXEC) begin
        case (held.op)
          CONO_MTR: begin
            acct = held.data.mtr.acctOn;
            timeOn = (timeOn & ~held.data.mtr.timeOnClr) | held.data.mtr.timeOnSet;
            if (held.data.mtr.clearTime)
              timeCycles = 0;
            if (held.data.mtr.clearEbox)
              ebox = '0;
            if (held.data.mtr.clearCache)
              cache = '0;
            if (held.data.mtr.clearPerf)
              perf = '0;
          end
          CONO_TIM: begin
            tIntOn = held.data.tim.intervalOn;
            tPeriod = held.data.tim.period;
            if (held.data.tim.clearInterval)
              tValue = '0;
            if (held.data.tim.clearDone) begin
              tDone = 1'b0;
              tOvf = 1'b0;
            end
          end
          LOAD_PA: mask = held.data.raw[5:0];
          default: ;
        endcase
      end

      case (state)
        HS_IDLE: begin
          if (req) begin
            held = cmd;
            state = HS_EXEC;
          end
        end
        HS_EXEC: state = HS_ACK;
        HS_ACK:  state = req ? HS_RELEASE : HS_IDLE;
        default: if (!req) state = HS_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* testbench/meter_clock.sv */
`timescale 1ns/10ps
`default_nettype none

module meterClock (
  output logic MBOX_CLK,
  output logic RESET
);

  initial begin
    MBOX_CLK = 1'b0;
    forever #10 MBOX_CLK = ~MBOX_CLK;
  end

  // Reset held for eight rising edges
  initial begin
    RESET = 1'b1;
    repeat (8) @(posedge MBOX_CLK);
    RESET <= 1'b0;
  end

endmodule

`default_nettype wire

/* testbench/meter_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "meter_settings.svh"

module meterTb;
  import meter_pkg::*;

  logic MBOX_CLK;
  logic RESET;
  logic req;
  meterCmd cmd;
  meterEvents events;
  logic ack;
  logic [`MTR_WORD_W-1:0] rdata;
  logic interrupt;
  int errorCount;
  logic hung;
  logic timeOnNow;
  logic [15:0] lfsr;

  meterClock clockGen (
    .MBOX_CLK (MBOX_CLK),
    .RESET    (RESET)
  );

  meterTop UUT (
    .MBOX_CLK  (MBOX_CLK),
    .RESET     (RESET),
    .req       (req),
    .cmd       (cmd),
    .events    (events),
    .ack       (ack),
    .rdata     (rdata),
    .interrupt (interrupt)
  );

  meterChecker scoreboard (
    .MBOX_CLK   (MBOX_CLK),
    .RESET      (RESET),
    .req        (req),
    .cmd        (cmd),
    .events     (events),
    .ack        (ack),
    .rdata      (rdata),
    .interrupt  (interrupt),
    .errorCount (errorCount)
  );

  // Galois LFSR, taps 16,14,13,11
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic takeBits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsrNext(lfsr);
    end
  endtask

  task automatic doCommand(input meterOp op, input meterSel sel, input meterWord data);
    int t;
    if (!hung) begin
      @(posedge MBOX_CLK);
      req <= 1'b1;
      cmd.op <= op;
      cmd.sel <= sel;
      cmd.data <= data;
      t = 0;
      do begin
        @(posedge MBOX_CLK);
        t++;
      end while (!ack && t < 20);
      if (!ack) begin
        $display("Timeout: ack never rose for a command");
        hung = 1'b1;
      end else begin
        req <= 1'b0;
        t = 0;
        do begin
          @(posedge MBOX_CLK);
          t++;
        end while (ack && t < 20);
        if (ack) begin
          $display("Timeout: ack stayed high after req dropped");
          hung = 1'b1;
        end
      end
    end
  endtask

  task automatic readAll();
    meterWord w;
    w = '0;
    doCommand(READ, TIME, w);
    doCommand(READ, PERF, w);
    doCommand(READ, EBOX, w);
    doCommand(READ, CACHE, w);
    doCommand(READ, INTERVAL, w);
    doCommand(READ, PERIOD, w);
    doCommand(READ, STATUS, w);
  endtask

  initial begin
    meterWord w;
    logic [31:0] r;
    logic [3:0] pSmall;
    int t;
    int p;
    int hold;
    req = 1'b0;
    cmd = '0;
    events = '0;
    hung = 1'b0;
    timeOnNow = 1'b0;
    lfsr = 16'd73;

    t = 0;
    do begin
      @(posedge MBOX_CLK);
      t++;
    end while (RESET && t < 50);
    if (RESET) begin
      $display("Timeout: reset never released");
      hung = 1'b1;
    end
    readAll();

    for (int iter = 0; iter < 12; iter++) begin
      w = '0;
      takeBits(6, r);
      w.mtr.acctOn = r[5];
      w.mtr.timeOnSet = r[4];
      w.mtr.timeOnClr = ~r[4];
      w.mtr.clearEbox = r[3];
      w.mtr.clearCache = r[2];
      w.mtr.clearPerf = r[1];
      // Restart the time meter whenever time on changes
      w.mtr.clearTime = r[0] | (r[4] != timeOnNow);
      timeOnNow = r[4];
      doCommand(CONO_MTR, TIME, w);
      readAll();
      takeBits(6, r);
      w = '0;
      w.raw[5:0] = r[5:0];
      doCommand(LOAD_PA, TIME, w);
      takeBits(6, r);
      hold = int'(r[5:0]) + 20;
      for (int c = 0; c < hold; c++) begin
        @(posedge MBOX_CLK);
        takeBits(6, r);
        events <= r[5:0];
      end
      @(posedge MBOX_CLK);
      events <= '0;
      readAll();
    end

    // Interval timer with a small period
    takeBits(3, r);
    pSmall = {1'b0, r[2:0]} + 4'd1;
    p = int'(pSmall);
    w = '0;
    w.tim.clearInterval = 1'b1;
    w.tim.clearDone = 1'b1;
    w.tim.intervalOn = 1'b1;
    w.tim.period[3:0] = pSmall;
    doCommand(CONO_TIM, STATUS, w);
    t = 0;
    while (!interrupt && t < (p + 3) * `MTR_USEC_DIV) begin
      @(posedge MBOX_CLK);
      t++;
    end
    if (!interrupt && !hung) begin
      $display("Timeout: interrupt never rose for period %0d", p);
      hung = 1'b1;
    end
    readAll();
    w.tim.clearInterval = 1'b0;
    w.tim.intervalOn = 1'b0;
    doCommand(CONO_TIM, STATUS, w);
    readAll();

    repeat (4) @(posedge MBOX_CLK);
    $display("Closing: %0d compare errors, timeout %0d", errorCount, hung);
    if (errorCount == 0 && !hung) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
rtl/meter_pkg.sv
rtl/meterControl.sv
rtl/meterTimebase.sv
rtl/meterCounters.sv
rtl/meterReadback.sv
rtl/meterTop.sv
testbench/meter_clock.sv
testbench/meter_checker.sv
testbench/meter_tb.sv
